// File: Bender.yml
package:
  name: blimp

sources:
  - src/blimp_pkg.sv
  - src/blimp_intf.sv
  - src/blimp_fetch.sv
  - src/blimp_decode.sv
  - src/blimp_execute.sv
  - src/blimp_result.sv
  - src/blimp_core.sv
  - target: test
    files:
      - verif/blimp_mem_model.sv
      - verif/blimp_tb.sv

// File: sources.f
src/blimp_pkg.sv
src/blimp_intf.sv
src/blimp_fetch.sv
src/blimp_decode.sv
src/blimp_execute.sv
src/blimp_result.sv
src/blimp_core.sv
verif/blimp_mem_model.sv
verif/blimp_tb.sv

// File: src/blimp_core.sv
/*
 * blimp core top level
 * Fetch, decode, execute and result behind plain memory and trace ports
 */
`default_nettype none

module blimp_core #(
  parameter blimp_pkg::word_t reset_addr = 32'h0000_0200
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  // Instruction memory
  output      logic                 imem_req_val,
  input  wire logic                 imem_req_rdy,
  output      blimp_pkg::word_t     imem_req_addr,
  input  wire logic                 imem_resp_val,
  output      logic                 imem_resp_rdy,
  input  wire blimp_pkg::word_t     imem_resp_data,
  // Data memory
  output      logic                 dmem_req_val,
  input  wire logic                 dmem_req_rdy,
  output      logic                 dmem_req_wen,
  output      blimp_pkg::word_t     dmem_req_addr,
  output      blimp_pkg::word_t     dmem_req_wdata,
  input  wire logic                 dmem_resp_val,
  output      logic                 dmem_resp_rdy,
  input  wire blimp_pkg::word_t     dmem_resp_rdata,
  // Retirement trace
  output      logic                 trace_val,
  output      blimp_pkg::word_t     trace_pc,
  output      blimp_pkg::reg_addr_t trace_waddr,
  output      blimp_pkg::word_t     trace_wdata,
  output      logic                 trace_wen
);
  import blimp_pkg::*;

  // Execute to result
  logic      x_val;
  logic      x_rdy;
  op_t       x_op;
  word_t     x_pc;
  reg_addr_t x_waddr;
  word_t     x_wdata;

  // Write-back to decode
  logic      wb_en;
  reg_addr_t wb_addr;
  word_t     wb_data;

  blimp_f2d_if f2d_if ();
  blimp_d2x_if d2x_if ();

  blimp_fetch #(
    .reset_addr (reset_addr)
  ) fetch_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .imem_req_val   (imem_req_val),
    .imem_req_rdy   (imem_req_rdy),
    .imem_req_addr  (imem_req_addr),
    .imem_resp_val  (imem_resp_val),
    .imem_resp_rdy  (imem_resp_rdy),
    .imem_resp_data (imem_resp_data),
    .f2d            (f2d_if.producer)
  );

  blimp_decode decode_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .f2d     (f2d_if.consumer),
    .d2x     (d2x_if.producer),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_data (wb_data)
  );

  blimp_execute execute_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .d2x            (d2x_if.consumer),
    .x_val          (x_val),
    .x_rdy          (x_rdy),
    .x_op           (x_op),
    .x_pc           (x_pc),
    .x_waddr        (x_waddr),
    .x_wdata        (x_wdata),
    .dmem_req_val   (dmem_req_val),
    .dmem_req_rdy   (dmem_req_rdy),
    .dmem_req_wen   (dmem_req_wen),
    .dmem_req_addr  (dmem_req_addr),
    .dmem_req_wdata (dmem_req_wdata)
  );

  blimp_result result_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .x_val           (x_val),
    .x_rdy           (x_rdy),
    .x_op            (x_op),
    .x_pc            (x_pc),
    .x_waddr         (x_waddr),
    .x_wdata         (x_wdata),
    .dmem_resp_val   (dmem_resp_val),
    .dmem_resp_rdy   (dmem_resp_rdy),
    .dmem_resp_rdata (dmem_resp_rdata),
    .wb_en           (wb_en),
    .wb_addr         (wb_addr),
    .wb_data         (wb_data),
    .trace_val       (trace_val),
    .trace_pc        (trace_pc),
    .trace_waddr     (trace_waddr),
    .trace_wdata     (trace_wdata),
    .trace_wen       (trace_wen)
  );

endmodule

`default_nettype wire

// File: src/blimp_decode.sv
/*
 * Decode stage of the blimp core
 * Register file, busy-bit scoreboard and operand issue to execute
 */
`default_nettype none

module blimp_decode (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  blimp_f2d_if.consumer             f2d,
  blimp_d2x_if.producer             d2x,
  input  wire logic                 wb_en,
  input  wire blimp_pkg::reg_addr_t wb_addr,
  input  wire blimp_pkg::word_t     wb_data
);
  import blimp_pkg::*;

  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_WORD = 3'b010;

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;
  word_t      imm_i;
  word_t      imm_s;
  op_t        op;
  reg_addr_t  waddr;
  logic       uses_rs2;
  word_t      rf [32];
  logic [31:0] busy;
  word_t      rs1_data;
  word_t      rs2_data;
  logic       rs1_busy;
  logic       rs2_busy;
  logic       rd_busy;
  logic       stall;
  logic       issue;

  // --------------------
  // Field extraction
  // --------------------

  assign opcode = f2d.inst[6:0];
  assign rd     = f2d.inst[11:7];
  assign funct3 = f2d.inst[14:12];
  assign rs1    = f2d.inst[19:15];
  assign rs2    = f2d.inst[24:20];
  assign funct7 = f2d.inst[31:25];

  // Sign-extended immediates
  assign imm_i = {{20{f2d.inst[31]}}, f2d.inst[31:20]};
  assign imm_s = {{20{f2d.inst[31]}}, f2d.inst[31:25], f2d.inst[11:7]};

  // Anything unknown falls through as addi to x0
  always_comb begin
    op       = OP_ADDI;
    waddr    = '0;
    uses_rs2 = 1'b0;
    case (opcode)
      OPC_OPIMM: begin
        if (funct3 == F3_ADD) waddr = rd;
      end
      OPC_OP: begin
        if (funct3 == F3_ADD) begin
          op       = (funct7 == FUNCT7_MUL) ? OP_MUL : OP_ADD;
          waddr    = rd;
          uses_rs2 = 1'b1;
        end
      end
      OPC_LOAD: begin
        if (funct3 == F3_WORD) begin
          op    = OP_LW;
          waddr = rd;
        end
      end
      OPC_STORE: begin
        if (funct3 == F3_WORD) begin
          op       = OP_SW;
          uses_rs2 = 1'b1;
        end
      end
      default: ;
    endcase
  end

  // --------------------
  // Register read
  // --------------------

  // x0 reads zero, write-back value forwarded
  always_comb begin
    if (rs1 == '0) rs1_data = '0;
    else if (wb_en && (wb_addr == rs1)) rs1_data = wb_data;
    else rs1_data = rf[rs1];

    if (rs2 == '0) rs2_data = '0;
    else if (wb_en && (wb_addr == rs2)) rs2_data = wb_data;
    else rs2_data = rf[rs2];
  end

  always_ff @(posedge clk) begin
    if (wb_en && (wb_addr != '0)) rf[wb_addr] <= wb_data;
  end

  // --------------------
  // Scoreboard
  // --------------------

  // A busy bit being cleared this cycle counts as free
  always_comb begin
    rs1_busy = busy[rs1] && !(wb_en && (wb_addr == rs1));
    rs2_busy = busy[rs2] && !(wb_en && (wb_addr == rs2));
    rd_busy  = busy[waddr] && !(wb_en && (wb_addr == waddr));
  end

  // Also hold back a second writer of a pending register
  assign stall = rs1_busy || (uses_rs2 && rs2_busy) || ((waddr != '0) && rd_busy);
  assign issue = f2d.val && f2d.rdy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= '0;
    end else begin
      if (wb_en) busy[wb_addr] <= 1'b0;
      // Set after clear, a new writer wins
      if (issue && (waddr != '0)) busy[waddr] <= 1'b1;
    end
  end

  // Issue to execute
  assign f2d.rdy = d2x.rdy && !stall;
  assign d2x.val = f2d.val && !stall;
  assign d2x.op  = op;
  assign d2x.pc  = f2d.pc;
  assign d2x.waddr = waddr;
  assign d2x.op_a  = rs1_data;
  // Memory ops add their offset like addi
  assign d2x.op_b  = uses_rs2 && (op != OP_SW) ? rs2_data : ((op == OP_SW) ? imm_s : imm_i);
  assign d2x.store_data = rs2_data;

endmodule

`default_nettype wire

// File: src/blimp_execute.sv
/*
 * Execute stage of the blimp core
 * Adder and low-word multiplier, data memory request issue
 */
`default_nettype none

module blimp_execute (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  blimp_d2x_if.consumer             d2x,
  output      logic                 x_val,
  input  wire logic                 x_rdy,
  output      blimp_pkg::op_t       x_op,
  output      blimp_pkg::word_t     x_pc,
  output      blimp_pkg::reg_addr_t x_waddr,
  output      blimp_pkg::word_t     x_wdata,
  output      logic                 dmem_req_val,
  input  wire logic                 dmem_req_rdy,
  output      logic                 dmem_req_wen,
  output      blimp_pkg::word_t     dmem_req_addr,
  output      blimp_pkg::word_t     dmem_req_wdata
);
  import blimp_pkg::*;

  logic      val_q;
  op_t       op_q;
  word_t     pc_q;
  reg_addr_t waddr_q;
  word_t     a_q;
  word_t     b_q;
  word_t     sd_q;
  logic      mem_op;
  logic      leave;
  word_t     sum;
  word_t     prod;

  // --------------------
  // Stage register
  // --------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      val_q <= 1'b0;
    end else if (d2x.rdy) begin
      val_q <= d2x.val;
    end
  end

  // Operands and tags
  always_ff @(posedge clk) begin
    if (d2x.val && d2x.rdy) begin
      op_q    <= d2x.op;
      pc_q    <= d2x.pc;
      waddr_q <= d2x.waddr;
      a_q     <= d2x.op_a;
      b_q     <= d2x.op_b;
      sd_q    <= d2x.store_data;
    end
  end

  // --------------------
  // Datapath
  // --------------------

  assign sum  = a_q + b_q;
  // Only the low word of the product is kept
  assign prod = a_q * b_q;

  assign mem_op = (op_q == OP_LW) || (op_q == OP_SW);

  // Memory ops need result and memory together
  assign leave   = val_q && x_rdy && (!mem_op || dmem_req_rdy);
  assign d2x.rdy = !val_q || leave;

  // To result
  assign x_val   = val_q && (!mem_op || dmem_req_rdy);
  assign x_op    = op_q;
  assign x_pc    = pc_q;
  assign x_waddr = waddr_q;
  always_comb begin
    case (op_q)
      OP_MUL:  x_wdata = prod;
      OP_SW:   x_wdata = sd_q;
      default: x_wdata = sum;
    endcase
  end

  // To data memory
  assign dmem_req_val   = val_q && mem_op && x_rdy;
  assign dmem_req_wen   = (op_q == OP_SW);
  assign dmem_req_addr  = sum;
  assign dmem_req_wdata = sd_q;

endmodule

`default_nettype wire

// File: src/blimp_fetch.sv
/*
 * Instruction fetch for the blimp core
 * One request in flight, sequential PC, one-entry buffer toward decode
 */
`default_nettype none

module blimp_fetch #(
  parameter blimp_pkg::word_t reset_addr = 32'h0000_0200
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  output      logic             imem_req_val,
  input  wire logic             imem_req_rdy,
  output      blimp_pkg::word_t imem_req_addr,
  input  wire logic             imem_resp_val,
  output      logic             imem_resp_rdy,
  input  wire blimp_pkg::word_t imem_resp_data,
  blimp_f2d_if.producer         f2d
);
  import blimp_pkg::*;

  fetch_state_e state;
  // Next request address
  word_t        pc_q;
  // Fetched word parked while decode is busy
  word_t        inst_q;
  // Low during reset, keeps the first request off the bus
  logic         run_q;

  // --------------------
  // Memory side
  // --------------------

  assign imem_req_val  = run_q && (state == FETCH_IDLE);
  assign imem_req_addr = pc_q;
  assign imem_resp_rdy = (state == FETCH_WAIT);

  // --------------------
  // Decode side
  // --------------------

  // PC already moved on at request time
  assign f2d.pc   = pc_q - 32'd4;
  assign f2d.inst = (state == FETCH_HOLD) ? inst_q : imem_resp_data;
  assign f2d.val  = ((state == FETCH_WAIT) && imem_resp_val) || (state == FETCH_HOLD);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= FETCH_IDLE;
      pc_q  <= reset_addr;
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      case (state)
        FETCH_IDLE: begin
          if (imem_req_val && imem_req_rdy) begin
            pc_q  <= pc_q + 32'd4;
            state <= FETCH_WAIT;
          end
        end
        FETCH_WAIT: begin
          // Straight through if decode takes it, else park it
          if (imem_resp_val) state <= f2d.rdy ? FETCH_IDLE : FETCH_HOLD;
        end
        FETCH_HOLD: begin
          if (f2d.rdy) state <= FETCH_IDLE;
        end
        default: state <= FETCH_IDLE;
      endcase
    end
  end

  // Buffer capture
  always_ff @(posedge clk) begin
    if ((state == FETCH_WAIT) && imem_resp_val && !f2d.rdy) inst_q <= imem_resp_data;
  end

endmodule

`default_nettype wire

// File: src/blimp_intf.sv
/*
 * Internal stage-to-stage channels of the blimp core
 * Fetch to decode, and decode to execute, both valid/ready
 */
`default_nettype none

// Fetched instruction on its way to decode
interface blimp_f2d_if;
  import blimp_pkg::*;

  logic  val;
  logic  rdy;
  word_t pc;
  word_t inst;

  modport producer (
    output val, pc, inst,
    input  rdy
  );

  modport consumer (
    input  val, pc, inst,
    output rdy
  );
endinterface

// Decoded instruction with its operands, issued to execute
interface blimp_d2x_if;
  import blimp_pkg::*;

  logic      val;
  logic      rdy;
  op_t       op;
  word_t     pc;
  reg_addr_t waddr;
  word_t     op_a;
  word_t     op_b;
  // rs2 value, only meaningful for sw
  word_t     store_data;

  modport producer (
    output val, op, pc, waddr, op_a, op_b, store_data,
    input  rdy
  );

  modport consumer (
    input  val, op, pc, waddr, op_a, op_b, store_data,
    output rdy
  );
endinterface

`default_nettype wire

// File: src/blimp_pkg.sv
/*
 * Shared types and constants for the blimp RV32 core
 * Word and register index types, decoded op codes, RV32 opcodes
 */
`default_nettype none

package blimp_pkg;

  // --------------------
  // Basic types
  // --------------------

  // Data, address or instruction word
  typedef logic [31:0] word_t;

  // Architectural register index
  typedef logic [4:0] reg_addr_t;

  // Decoded operation
  typedef logic [2:0] op_t;

  localparam op_t OP_ADD  = 3'd0;
  localparam op_t OP_ADDI = 3'd1;
  localparam op_t OP_MUL  = 3'd2;
  localparam op_t OP_LW   = 3'd3;
  localparam op_t OP_SW   = 3'd4;

  // --------------------
  // RV32 encodings
  // --------------------

  // Major opcodes
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  // M extension marker in funct7
  localparam logic [6:0] FUNCT7_MUL = 7'b0000001;

  // Fetch FSM
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_WAIT,
    FETCH_HOLD
  } fetch_state_e;

endpackage

`default_nettype wire

// File: src/blimp_result.sv
/*
 * Result stage of the blimp core
 * Waits on data responses, writes back and reports retirements
 */
`default_nettype none

module blimp_result (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 x_val,
  output      logic                 x_rdy,
  input  wire blimp_pkg::op_t       x_op,
  input  wire blimp_pkg::word_t     x_pc,
  input  wire blimp_pkg::reg_addr_t x_waddr,
  input  wire blimp_pkg::word_t     x_wdata,
  input  wire logic                 dmem_resp_val,
  output      logic                 dmem_resp_rdy,
  input  wire blimp_pkg::word_t     dmem_resp_rdata,
  output      logic                 wb_en,
  output      blimp_pkg::reg_addr_t wb_addr,
  output      blimp_pkg::word_t     wb_data,
  output      logic                 trace_val,
  output      blimp_pkg::word_t     trace_pc,
  output      blimp_pkg::reg_addr_t trace_waddr,
  output      blimp_pkg::word_t     trace_wdata,
  output      logic                 trace_wen
);
  import blimp_pkg::*;

  // Memory op waiting on its response
  logic      pend_val;
  op_t       pend_op;
  word_t     pend_pc;
  reg_addr_t pend_waddr;
  logic      x_mem;
  logic      x_fire;
  logic      retire_alu;
  logic      retire_mem;
  op_t       r_op;
  word_t     r_pc;
  reg_addr_t r_waddr;
  word_t     r_data;
  logic      r_wen;

  assign x_mem = (x_op == OP_LW) || (x_op == OP_SW);

  // Nothing passes a pending memory op, keeps program order
  assign x_rdy         = !pend_val;
  assign dmem_resp_rdy = pend_val;

  assign x_fire     = x_val && x_rdy;
  assign retire_alu = x_fire && !x_mem;
  assign retire_mem = pend_val && dmem_resp_val;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend_val <= 1'b0;
    end else if (x_fire && x_mem) begin
      pend_val <= 1'b1;
    end else if (retire_mem) begin
      pend_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (x_fire && x_mem) begin
      pend_op    <= x_op;
      pend_pc    <= x_pc;
      pend_waddr <= x_waddr;
    end
  end

  // --------------------
  // Retirement select
  // --------------------

  always_comb begin
    if (pend_val) begin
      r_op    = pend_op;
      r_pc    = pend_pc;
      r_waddr = pend_waddr;
      r_data  = dmem_resp_rdata;
    end else begin
      r_op    = x_op;
      r_pc    = x_pc;
      r_waddr = x_waddr;
      r_data  = x_wdata;
    end
  end

  // No register write for sw or x0
  assign r_wen = (r_op != OP_SW) && (r_waddr != '0);

  // Trace and write-back
  assign trace_val   = retire_alu || retire_mem;
  assign trace_wen   = trace_val && r_wen;
  assign trace_pc    = r_pc;
  assign trace_waddr = r_waddr;
  assign trace_wdata = trace_wen ? r_data : '0;

  assign wb_en   = trace_wen;
  assign wb_addr = r_waddr;
  assign wb_data = r_data;

endmodule

`default_nettype wire

// File: verif/blimp_mem_model.sv
/*
 * Test memory for the blimp core
 * Instruction and data ports over one array, in-order responses, optional random stalls
 */
`default_nettype none

module blimp_mem_model (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             stall_en,
  input  wire logic             imem_req_val,
  output      logic             imem_req_rdy,
  input  wire blimp_pkg::word_t imem_req_addr,
  output      logic             imem_resp_val,
  input  wire logic             imem_resp_rdy,
  output      blimp_pkg::word_t imem_resp_data,
  input  wire logic             dmem_req_val,
  output      logic             dmem_req_rdy,
  input  wire logic             dmem_req_wen,
  input  wire blimp_pkg::word_t dmem_req_addr,
  input  wire blimp_pkg::word_t dmem_req_wdata,
  output      logic             dmem_resp_val,
  input  wire logic             dmem_resp_rdy,
  output      blimp_pkg::word_t dmem_resp_rdata
);
  timeunit 1ns;
  timeprecision 1ps;
  import blimp_pkg::*;

  localparam int WORDS = 1024;

  word_t  mem [WORDS];
  integer seed;
  // One response slot per port
  logic   i_pend;
  logic   d_pend;
  word_t  i_data;
  word_t  d_data;
  // Stall bits, redrawn every cycle
  logic   i_req_stall;
  logic   i_resp_stall;
  logic   d_req_stall;
  logic   d_resp_stall;

  // Word slot of a byte address, upper bits alias
  function automatic int slot(input word_t addr);
    return int'(addr[11:2]);
  endfunction

  // --------------------
  // Preload
  // --------------------

  task automatic fill_pattern();
    word_t a;
    for (int i = 0; i < WORDS; i++) begin
      a = word_t'(i) << 2;
      mem[i] = (a * 32'h9E37_79B1) ^ a;
    end
  endtask

  task automatic write_word(input word_t addr, input word_t data);
    mem[slot(addr)] = data;
  endtask

  assign imem_req_rdy    = !i_pend && !i_req_stall;
  assign imem_resp_val   = i_pend && !i_resp_stall;
  assign imem_resp_data  = i_data;
  assign dmem_req_rdy    = !d_pend && !d_req_stall;
  assign dmem_resp_val   = d_pend && !d_resp_stall;
  assign dmem_resp_rdata = d_data;

  // --------------------
  // Port behavior
  // --------------------

  initial begin
    logic  i_req_fire;
    logic  i_resp_fire;
    logic  d_req_fire;
    logic  d_resp_fire;
    logic  in_reset;
    logic  stalls_on;
    word_t i_next;
    word_t d_next;
    seed         = 32'h9749_f502;
    i_pend       = 1'b0;
    d_pend       = 1'b0;
    i_data       = '0;
    d_data       = '0;
    i_req_stall  = 1'b0;
    i_resp_stall = 1'b0;
    d_req_stall  = 1'b0;
    d_resp_stall = 1'b0;
    forever begin
      // Handshakes sampled mid-cycle, where they are settled
      @(negedge clk);
      i_req_fire  = imem_req_val && imem_req_rdy;
      i_resp_fire = imem_resp_val && imem_resp_rdy;
      d_req_fire  = dmem_req_val && dmem_req_rdy;
      d_resp_fire = dmem_resp_val && dmem_resp_rdy;
      in_reset    = !rst_n;
      stalls_on   = stall_en;
      i_next      = '0;
      d_next      = '0;
      if (i_req_fire) i_next = mem[slot(imem_req_addr)];
      // Store answers with zero data
      if (d_req_fire) begin
        if (dmem_req_wen) mem[slot(dmem_req_addr)] = dmem_req_wdata;
        else d_next = mem[slot(dmem_req_addr)];
      end
      // New outputs just after the edge
      @(posedge clk);
      #2;
      if (in_reset) begin
        i_pend = 1'b0;
        d_pend = 1'b0;
      end else begin
        if (i_resp_fire) i_pend = 1'b0;
        if (d_resp_fire) d_pend = 1'b0;
        if (i_req_fire) begin
          i_pend = 1'b1;
          i_data = i_next;
        end
        if (d_req_fire) begin
          d_pend = 1'b1;
          d_data = d_next;
        end
      end
      i_req_stall  = stalls_on && (($random(seed) & 3) == 0);
      i_resp_stall = stalls_on && (($random(seed) & 3) == 0);
      d_req_stall  = stalls_on && (($random(seed) & 3) == 0);
      d_resp_stall = stalls_on && (($random(seed) & 3) == 0);
    end
  end

endmodule

`default_nettype wire

// File: verif/blimp_tb.sv
/*
 * Testbench for the blimp core
 * Directed programs, each retirement checked against a reference model
 */
`default_nettype none

module blimp_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import blimp_pkg::*;

  localparam word_t RESET_ADDR = 32'h0000_0200;
  localparam word_t NOP        = 32'h0000_0013;
  // Four programs, run without and with stalls
  localparam int PASS_INSTS  = 38;
  localparam int CYCLE_LIMIT = 60 * 2 * PASS_INSTS + 8 * 16;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      stall_en;
  logic      imem_req_val;
  logic      imem_req_rdy;
  word_t     imem_req_addr;
  logic      imem_resp_val;
  logic      imem_resp_rdy;
  word_t     imem_resp_data;
  logic      dmem_req_val;
  logic      dmem_req_rdy;
  logic      dmem_req_wen;
  word_t     dmem_req_addr;
  word_t     dmem_req_wdata;
  logic      dmem_resp_val;
  logic      dmem_resp_rdy;
  word_t     dmem_resp_rdata;
  logic      trace_val;
  word_t     trace_pc;
  reg_addr_t trace_waddr;
  word_t     trace_wdata;
  logic      trace_wen;

  // Program image and expected retirements
  word_t     prog [$];
  word_t     exp_pc [$];
  reg_addr_t exp_waddr [$];
  logic      exp_wen [$];
  word_t     exp_wdata [$];
  // Reference architectural state
  word_t     ref_rf [32];
  word_t     ref_mem [word_t];
  int        cycles;

  blimp_core #(
    .reset_addr (RESET_ADDR)
  ) dut_i (
    .clk (clk), .rst_n (rst_n),
    .imem_req_val (imem_req_val), .imem_req_rdy (imem_req_rdy),
    .imem_req_addr (imem_req_addr), .imem_resp_val (imem_resp_val),
    .imem_resp_rdy (imem_resp_rdy), .imem_resp_data (imem_resp_data),
    .dmem_req_val (dmem_req_val), .dmem_req_rdy (dmem_req_rdy),
    .dmem_req_wen (dmem_req_wen), .dmem_req_addr (dmem_req_addr),
    .dmem_req_wdata (dmem_req_wdata), .dmem_resp_val (dmem_resp_val),
    .dmem_resp_rdy (dmem_resp_rdy), .dmem_resp_rdata (dmem_resp_rdata),
    .trace_val (trace_val), .trace_pc (trace_pc), .trace_waddr (trace_waddr),
    .trace_wdata (trace_wdata), .trace_wen (trace_wen)
  );

  blimp_mem_model mem_i (
    .clk (clk), .rst_n (rst_n), .stall_en (stall_en),
    .imem_req_val (imem_req_val), .imem_req_rdy (imem_req_rdy),
    .imem_req_addr (imem_req_addr), .imem_resp_val (imem_resp_val),
    .imem_resp_rdy (imem_resp_rdy), .imem_resp_data (imem_resp_data),
    .dmem_req_val (dmem_req_val), .dmem_req_rdy (dmem_req_rdy),
    .dmem_req_wen (dmem_req_wen), .dmem_req_addr (dmem_req_addr),
    .dmem_req_wdata (dmem_req_wdata), .dmem_resp_val (dmem_resp_val),
    .dmem_resp_rdy (dmem_resp_rdy), .dmem_resp_rdata (dmem_resp_rdata)
  );

  always #20 clk = ~clk;

  // --------------------
  // Error handling
  // --------------------

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "Stopping at first error");
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT)
      report_error($sformatf("Timeout after %0d cycles, %0d expected retirements never came",
                             cycles, exp_pc.size()));
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
      report_error($sformatf("FAIL at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp)
      report_error($sformatf("FAIL at %0t: %s got %0d expected %0d", $time, name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_error($sformatf("FAIL at %0t: %s got %b expected %b", $time, name, got, exp));
  endtask

  // --------------------
  // Encoders
  // --------------------

  function automatic word_t i_type(input int imm, input reg_addr_t rs1,
                                   input logic [2:0] funct3, input reg_addr_t rd,
                                   input logic [6:0] opcode);
    return {imm[11:0], rs1, funct3, rd, opcode};
  endfunction

  function automatic word_t r_type(input logic [6:0] funct7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input reg_addr_t rd);
    return {funct7, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic word_t s_type(input int imm, input reg_addr_t rs2, input reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  // --------------------
  // Reference model
  // --------------------

  function automatic word_t reg_val(input reg_addr_t r);
    return (r == 0) ? '0 : ref_rf[r];
  endfunction

  // Appends one instruction and the trace it should retire with
  task automatic expect_retire(input word_t inst, input reg_addr_t rd, input word_t value);
    exp_pc.push_back(RESET_ADDR + 32'(4 * prog.size()));
    prog.push_back(inst);
    exp_waddr.push_back(rd);
    exp_wen.push_back(rd != 0);
    exp_wdata.push_back((rd != 0) ? value : '0);
    if (rd != 0) ref_rf[rd] = value;
  endtask

  task automatic addi(input reg_addr_t rd, input reg_addr_t rs1, input int imm);
    expect_retire(i_type(imm, rs1, 3'b000, rd, 7'b0010011), rd, reg_val(rs1) + word_t'(imm));
  endtask

  task automatic add(input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
    expect_retire(r_type(7'b0000000, rs2, rs1, rd), rd, reg_val(rs1) + reg_val(rs2));
  endtask

  // Low word of the product
  task automatic mul(input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
    expect_retire(r_type(7'b0000001, rs2, rs1, rd), rd, reg_val(rs1) * reg_val(rs2));
  endtask

  task automatic lw(input reg_addr_t rd, input reg_addr_t rs1, input int imm);
    word_t addr;
    addr = reg_val(rs1) + word_t'(imm);
    if (!ref_mem.exists(addr))
      report_error($sformatf("Test program loads from %h, which it never stored", addr));
    expect_retire(i_type(imm, rs1, 3'b010, rd, 7'b0000011), rd, ref_mem[addr]);
  endtask

  // Stores retire with no register write
  task automatic sw(input reg_addr_t rs2, input reg_addr_t rs1, input int imm);
    ref_mem[reg_val(rs1) + word_t'(imm)] = reg_val(rs2);
    expect_retire(s_type(imm, rs2, rs1), 5'd0, '0);
  endtask

  // --------------------
  // Run control
  // --------------------

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic begin_program();
    prog.delete();
    exp_pc.delete();
    exp_waddr.delete();
    exp_wen.delete();
    exp_wdata.delete();
    ref_mem.delete();
  endtask

  task automatic check_trace();
    check_word("trace_pc", trace_pc, exp_pc.pop_front());
    check_reg("trace_waddr", trace_waddr, exp_waddr.pop_front());
    check_flag("trace_wen", trace_wen, exp_wen.pop_front());
    check_word("trace_wdata", trace_wdata, exp_wdata.pop_front());
  endtask

  task automatic run_program(input string name);
    rst_n = 1'b0;
    repeat (8) step();
    mem_i.fill_pattern();
    foreach (prog[i]) mem_i.write_word(RESET_ADDR + 32'(4 * i), prog[i]);
    // Fetch runs past the end, nops there retire harmlessly
    for (int i = 0; i < 16; i++)
      mem_i.write_word(RESET_ADDR + 32'(4 * (prog.size() + i)), NOP);
    rst_n = 1'b1;
    while (exp_pc.size() > 0) begin
      @(negedge clk);
      if (trace_val === 1'b1) check_trace();
    end
    step();
    $display("%s: %0d instructions retired, stalls %0d", name, prog.size(), stall_en);
  endtask

  // --------------------
  // Directed tests
  // --------------------

  task automatic test_addi_chain();
    begin_program();
    addi(1, 0, 5);
    addi(2, 0, -1);
    addi(3, 1, -10);
    addi(4, 3, 2047);
    addi(1, 1, -2048);
    addi(2, 2, 1);
    run_program("addi chain");
  endtask

  // Back-to-back dependences hit the scoreboard and bypass
  task automatic test_add_mul();
    begin_program();
    addi(1, 0, 7);
    addi(2, 0, -3);
    add(3, 1, 2);
    mul(4, 3, 1);
    mul(5, 2, 2);
    addi(6, 0, 2047);
    mul(7, 6, 6);
    mul(8, 7, 7);
    add(9, 8, 4);
    mul(10, 9, 2);
    add(1, 1, 1);
    run_program("add and mul");
  endtask

  task automatic test_load_store();
    begin_program();
    addi(5, 0, 'h600);
    addi(1, 0, 123);
    sw(1, 5, 0);
    addi(2, 0, -77);
    sw(2, 5, 4);
    lw(3, 5, 0);
    lw(4, 5, 4);
    add(6, 3, 4);
    sw(6, 5, -8);
    lw(7, 5, -8);
    sw(7, 5, 0);
    lw(8, 5, 0);
    run_program("load and store");
  endtask

  task automatic test_x0_writes();
    begin_program();
    addi(0, 0, 55);
    addi(1, 0, 9);
    add(0, 1, 1);
    mul(0, 1, 1);
    addi(5, 0, 'h600);
    sw(1, 5, 0);
    lw(0, 5, 0);
    add(2, 0, 1);
    add(3, 0, 0);
    run_program("x0 writes");
  endtask

  task automatic test_random_stalls();
    stall_en = 1'b1;
    test_addi_chain();
    test_add_mul();
    test_load_store();
    test_x0_writes();
  endtask

  initial begin
    rst_n    = 1'b0;
    stall_en = 1'b0;
    cycles   = 0;
    test_addi_chain();
    test_add_mul();
    test_load_store();
    test_x0_writes();
    test_random_stalls();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire
